// ==== source/can_reg_pkg.sv ====
// Extended register mode only; addresses are byte offsets on an 8-bit host bus
package can_reg_pkg;

  // ##########################################################################
  // Register map
  // ##########################################################################

  localparam logic [7:0] addr_mode           = 8'd0;
  localparam logic [7:0] addr_command        = 8'd1;
  localparam logic [7:0] addr_status         = 8'd2;
  localparam logic [7:0] addr_irq            = 8'd3;
  localparam logic [7:0] addr_irq_en         = 8'd4;
  localparam logic [7:0] addr_bus_timing_0   = 8'd6;
  localparam logic [7:0] addr_bus_timing_1   = 8'd7;
  localparam logic [7:0] addr_err_warn_limit = 8'd13;
  localparam logic [7:0] addr_rx_err_cnt     = 8'd14;
  localparam logic [7:0] addr_tx_err_cnt     = 8'd15;
  // Four code bytes, then four mask bytes
  localparam logic [7:0] addr_acc_code_base  = 8'd16;
  localparam logic [7:0] addr_acc_mask_base  = 8'd20;

  localparam logic [7:0] err_warn_limit_reset = 8'd96;
  localparam int         data_w               = 8;

  // ##########################################################################
  // Register layouts
  // ##########################################################################

  // Bit 0 is reset mode, as in the mode register
  typedef struct packed {
    logic acceptance_filter_mode;
    logic self_test_mode;
    logic listen_only_mode;
    logic reset_mode;
  } mode_t;

  // Transmit controls towards the protocol core
  typedef struct packed {
    logic tx_request;
    logic abort_tx;
    logic release_buffer;
    logic clear_data_overrun;
    logic self_rx_request;
    logic single_shot_transmission;
  } command_t;

  // Low byte is bus timing 0, high byte is bus timing 1
  typedef struct packed {
    logic       triple_sampling;
    logic [2:0] time_segment2;
    logic [3:0] time_segment1;
    logic [1:0] sync_jump_width;
    logic [5:0] baud_r_presc;
  } bus_timing_t;

  // Code bytes in lanes 0 to 3, mask bytes in lanes 4 to 7
  typedef struct packed {
    logic [3:0][7:0] acc_mask;
    logic [3:0][7:0] acc_code;
  } acc_filter_t;

  // Protocol core state seen by the register file
  typedef struct packed {
    logic sample_point;
    logic transmitting;
    logic node_bus_off;
    logic error_status;
    logic transmit_status;
    logic receive_status;
    logic tx_successful;
    logic need_to_tx;
    logic overrun;
    logic info_empty;
    logic set_bus_error_irq;
    logic set_arbitration_lost_irq;
    logic node_error_passive;
    logic node_error_active;
    logic tx_state;
    logic tx_state_q;
  } core_status_t;

  // Interrupt and interrupt enable layout, bit 4 reserved
  typedef struct packed {
    logic bus_error;
    logic arbitration_lost;
    logic error_passive;
    logic reserved;
    logic data_overrun;
    logic error_warning;
    logic transmit;
    logic receive;
  } irq_flags_t;

endpackage

// ==== source/can_cfg_bank.sv ====
// Payload width must be a whole number of bytes; at most one lane written per cycle
`timescale 1ns/1ns

module can_cfg_bank #(
  parameter type field_t = logic [7:0],
  localparam int lanes   = $bits(field_t) / 8
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [lanes-1:0]               lane_we,
  input  logic [can_reg_pkg::data_w-1:0] data_in,
  output field_t                         fields
);

  logic [lanes-1:0][7:0] lane_q;

  // Each strobe loads its own byte of the payload
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      lane_q <= '0;
    end else begin
      for (int i = 0; i < lanes; i++) begin
        if (lane_we[i]) begin
          lane_q[i] <= data_in;
        end
      end
    end
  end

  // Lane 0 lands in the low byte of the struct
  assign fields = field_t'(lane_q);

  // One host write addresses a single byte
  assert property (@(posedge clk) disable iff (rst) $onehot0(lane_we));

endmodule

// ==== source/can_reg_ctrl.sv ====
// Timing, filter and error limit writes are dropped unless reset mode is set
`timescale 1ns/1ns

module can_reg_ctrl (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           we,
  input  logic                           re,
  input  logic [7:0]                     addr_write,
  input  logic [7:0]                     addr_read,
  input  logic [can_reg_pkg::data_w-1:0] data_in,
  input  can_reg_pkg::core_status_t      core_status,
  output can_reg_pkg::mode_t             mode,
  output can_reg_pkg::command_t          command,
  output can_reg_pkg::irq_flags_t        irq_en,
  output logic [7:0]                     err_warn_limit,
  output logic [1:0]                     timing_we,
  output logic [7:0]                     filter_we,
  output logic                           read_irq
);

  logic       cfg_wr;
  logic       wr_cmd;
  logic       tx_fall;
  logic [4:0] cmd_q;
  logic [4:0] cmd_clr;
  logic       self_rx_q;
  logic       single_shot_q;

  // Configuration writes only while the controller is held in reset mode
  assign cfg_wr   = we && mode.reset_mode;
  assign wr_cmd   = we && (addr_write == can_reg_pkg::addr_command);
  assign read_irq = re && (addr_read == can_reg_pkg::addr_irq);
  // End of a transmission
  assign tx_fall  = !core_status.tx_state && core_status.tx_state_q;

  // ##########################################################################
  // Mode, interrupt enable, error limit
  // ##########################################################################

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mode           <= '{reset_mode: 1'b1, default: 1'b0};
      irq_en         <= '0;
      err_warn_limit <= can_reg_pkg::err_warn_limit_reset;
    end else if (we) begin
      if (addr_write == can_reg_pkg::addr_mode) begin
        mode.reset_mode <= data_in[0];
        // Operating mode bits only change while in reset mode
        if (mode.reset_mode) begin
          mode.listen_only_mode       <= data_in[1];
          mode.self_test_mode         <= data_in[2];
          mode.acceptance_filter_mode <= data_in[3];
        end
      end
      if (addr_write == can_reg_pkg::addr_irq_en) begin
        irq_en <= data_in;
      end
      if (cfg_wr && addr_write == can_reg_pkg::addr_err_warn_limit) begin
        err_warn_limit <= data_in;
      end
    end
  end

  // Byte lane strobes for the two configuration banks
  always_comb begin
    timing_we[0] = cfg_wr && (addr_write == can_reg_pkg::addr_bus_timing_0);
    timing_we[1] = cfg_wr && (addr_write == can_reg_pkg::addr_bus_timing_1);
    for (int i = 0; i < 4; i++) begin
      filter_we[i]     = cfg_wr && (addr_write == can_reg_pkg::addr_acc_code_base + 8'(i));
      filter_we[i + 4] = cfg_wr && (addr_write == can_reg_pkg::addr_acc_mask_base + 8'(i));
    end
  end

  // ##########################################################################
  // Self-clearing command bits
  // ##########################################################################

  // Bits: 0 tx request, 1 abort, 2 release buffer, 3 clear overrun, 4 self rx
  always_comb begin
    cmd_clr[0] = cmd_q[0] && core_status.sample_point;
    cmd_clr[1] = core_status.sample_point &&
                 (command.tx_request || (command.abort_tx && !core_status.transmitting));
    // Buffer release and overrun clear live for one cycle
    cmd_clr[2] = |cmd_q[3:2];
    cmd_clr[3] = |cmd_q[3:2];
    cmd_clr[4] = cmd_q[4] && core_status.sample_point;
    // Entering reset mode drops every pending command
    cmd_clr    = cmd_clr | {5{mode.reset_mode}};
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cmd_q <= '0;
    end else begin
      for (int i = 0; i < 5; i++) begin
        if (cmd_clr[i]) begin
          cmd_q[i] <= 1'b0;
        end else if (wr_cmd) begin
          cmd_q[i] <= data_in[i];
        end
      end
    end
  end

  // Self reception and single shot stay up until the frame is done
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      self_rx_q     <= 1'b0;
      single_shot_q <= 1'b0;
    end else begin
      if (cmd_q[4] && !cmd_q[0]) begin
        self_rx_q <= 1'b1;
      end else if (tx_fall) begin
        self_rx_q <= 1'b0;
      end
      // Request together with abort means one attempt only
      if (command.tx_request && cmd_q[1] && core_status.sample_point) begin
        single_shot_q <= 1'b1;
      end else if (tx_fall) begin
        single_shot_q <= 1'b0;
      end
    end
  end

  always_comb begin
    command.tx_request               = cmd_q[0] || cmd_q[4];
    command.abort_tx                 = cmd_q[1] && !command.tx_request;
    command.release_buffer           = cmd_q[2];
    command.clear_data_overrun       = cmd_q[3];
    command.self_rx_request          = self_rx_q;
    command.single_shot_transmission = single_shot_q;
  end

  // Buffer release and overrun clear reach the core as single-cycle pulses
  assert property (@(posedge clk) disable iff (rst)
    (command.release_buffer || command.clear_data_overrun) |=>
      !(command.release_buffer || command.clear_data_overrun));

endmodule

// ==== source/can_status_regs.sv ====
// Status byte is read-only; the upper four bits pass straight from the core
`timescale 1ns/1ns

module can_status_regs (
  input  logic                      clk,
  input  logic                      rst,
  input  can_reg_pkg::core_status_t core_status,
  input  can_reg_pkg::mode_t        mode,
  input  can_reg_pkg::command_t     command,
  output logic [7:0]                status,
  output logic                      tx_buffer_rise,
  output logic                      overrun_rise
);

  logic tx_successful_q;
  logic overrun_q;
  logic tx_buffer_status_q;
  logic transmission_complete;
  logic tx_buffer_status;
  logic overrun_status;
  logic rx_buffer_status;

  // Previous values for edge detection
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tx_successful_q    <= 1'b0;
      overrun_q          <= 1'b0;
      tx_buffer_status_q <= 1'b1;
    end else begin
      tx_successful_q    <= core_status.tx_successful;
      overrun_q          <= core_status.overrun;
      tx_buffer_status_q <= tx_buffer_status;
    end
  end

  assign tx_buffer_rise = tx_buffer_status && !tx_buffer_status_q;
  assign overrun_rise   = core_status.overrun && !overrun_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      transmission_complete <= 1'b1;
      tx_buffer_status      <= 1'b1;
      overrun_status        <= 1'b0;
      rx_buffer_status      <= 1'b0;
    end else begin
      // Completion on a good frame or an abort
      if ((core_status.tx_successful && !tx_successful_q) || command.abort_tx) begin
        transmission_complete <= 1'b1;
      end else if (command.tx_request) begin
        transmission_complete <= 1'b0;
      end
      // Buffer locked from request until the core is done with it
      if (command.tx_request) begin
        tx_buffer_status <= 1'b0;
      end else if (mode.reset_mode || !core_status.need_to_tx) begin
        tx_buffer_status <= 1'b1;
      end
      if (overrun_rise) begin
        overrun_status <= 1'b1;
      end else if (mode.reset_mode || command.clear_data_overrun) begin
        overrun_status <= 1'b0;
      end
      // Receive FIFO holds at least one message
      if (mode.reset_mode || command.release_buffer) begin
        rx_buffer_status <= 1'b0;
      end else if (!core_status.info_empty) begin
        rx_buffer_status <= 1'b1;
      end
    end
  end

  assign status = {core_status.node_bus_off, core_status.error_status,
                   core_status.transmit_status, core_status.receive_status,
                   transmission_complete, tx_buffer_status,
                   overrun_status, rx_buffer_status};

endmodule

// ==== source/can_irq_unit.sv ====
// Level interrupt on irq_n; reading the interrupt register releases it for a cycle
`timescale 1ns/1ns

module can_irq_unit (
  input  logic                      clk,
  input  logic                      rst,
  input  can_reg_pkg::core_status_t core_status,
  input  can_reg_pkg::mode_t        mode,
  input  can_reg_pkg::command_t     command,
  input  can_reg_pkg::irq_flags_t   irq_en,
  input  logic                      read_irq,
  input  logic                      tx_buffer_rise,
  input  logic                      overrun_rise,
  output can_reg_pkg::irq_flags_t   irq_flags,
  output logic                      irq_n
);

  logic error_status_q;
  logic node_bus_off_q;
  logic node_error_passive_q;
  logic warn_change;
  logic passive_change;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      error_status_q       <= 1'b0;
      node_bus_off_q       <= 1'b0;
      node_error_passive_q <= 1'b0;
    end else begin
      error_status_q       <= core_status.error_status;
      node_bus_off_q       <= core_status.node_bus_off;
      node_error_passive_q <= core_status.node_error_passive;
    end
  end

  // Any move across the warning limit or into bus off
  assign warn_change = (core_status.error_status ^ error_status_q) ||
                       (core_status.node_bus_off ^ node_bus_off_q);
  // Into passive, or back out to active
  assign passive_change = (core_status.node_error_passive && !node_error_passive_q) ||
                          (!core_status.node_error_passive && node_error_passive_q &&
                           core_status.node_error_active);

  // ##########################################################################
  // Interrupt flags
  // ##########################################################################

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      irq_flags <= '0;
    end else begin
      irq_flags.reserved <= 1'b0;
      if (overrun_rise && irq_en.data_overrun) begin
        irq_flags.data_overrun <= 1'b1;
      end else if (mode.reset_mode || read_irq) begin
        irq_flags.data_overrun <= 1'b0;
      end
      // Read or reset mode clear wins over a buffer release in the same cycle
      if (mode.reset_mode || read_irq) begin
        irq_flags.transmit <= 1'b0;
      end else if (tx_buffer_rise && irq_en.transmit) begin
        irq_flags.transmit <= 1'b1;
      end
      // Receive stays up until the host frees the buffer
      if (!core_status.info_empty && !irq_flags.receive && irq_en.receive) begin
        irq_flags.receive <= 1'b1;
      end else if (mode.reset_mode || command.release_buffer) begin
        irq_flags.receive <= 1'b0;
      end
      // Not touched by reset mode
      if (warn_change && irq_en.error_warning) begin
        irq_flags.error_warning <= 1'b1;
      end else if (read_irq) begin
        irq_flags.error_warning <= 1'b0;
      end
      if (core_status.set_bus_error_irq && irq_en.bus_error) begin
        irq_flags.bus_error <= 1'b1;
      end else if (mode.reset_mode || read_irq) begin
        irq_flags.bus_error <= 1'b0;
      end
      if (core_status.set_arbitration_lost_irq && irq_en.arbitration_lost) begin
        irq_flags.arbitration_lost <= 1'b1;
      end else if (mode.reset_mode || read_irq) begin
        irq_flags.arbitration_lost <= 1'b0;
      end
      if (passive_change && irq_en.error_passive) begin
        irq_flags.error_passive <= 1'b1;
      end else if (mode.reset_mode || read_irq) begin
        irq_flags.error_passive <= 1'b0;
      end
    end
  end

  // Released for one cycle on a read so edge-triggered hosts see a new edge
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      irq_n <= 1'b1;
    end else if (read_irq || command.release_buffer) begin
      irq_n <= 1'b1;
    end else if (|irq_flags) begin
      irq_n <= 1'b0;
    end
  end

  assert property (@(posedge clk) disable iff (rst) read_irq |=> irq_n);

endmodule

// ==== source/can_registers.sv ====
// Reads have no side effect except the interrupt register; unmapped addresses read zero
`timescale 1ns/1ns

module can_registers (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           we,
  input  logic                           re,
  input  logic [7:0]                     addr_write,
  input  logic [7:0]                     addr_read,
  input  logic [can_reg_pkg::data_w-1:0] data_in,
  input  can_reg_pkg::core_status_t      core_status,
  input  logic [7:0]                     rx_err_cnt,
  input  logic [7:0]                     tx_err_cnt,
  output logic [can_reg_pkg::data_w-1:0] data_out,
  output logic                           irq_n,
  output can_reg_pkg::mode_t             mode,
  output can_reg_pkg::command_t          command,
  output can_reg_pkg::bus_timing_t       bus_timing,
  output can_reg_pkg::acc_filter_t       acc_filter,
  output logic [7:0]                     err_warn_limit
);

  can_reg_pkg::irq_flags_t irq_en;
  can_reg_pkg::irq_flags_t irq_flags;
  logic [1:0]              timing_we;
  logic [7:0]              filter_we;
  logic                    read_irq;
  logic [7:0]              status;
  logic                    tx_buffer_rise;
  logic                    overrun_rise;

  can_reg_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .we             (we),
    .re             (re),
    .addr_write     (addr_write),
    .addr_read      (addr_read),
    .data_in        (data_in),
    .core_status    (core_status),
    .mode           (mode),
    .command        (command),
    .irq_en         (irq_en),
    .err_warn_limit (err_warn_limit),
    .timing_we      (timing_we),
    .filter_we      (filter_we),
    .read_irq       (read_irq)
  );

  // Bus timing 0 and 1
  can_cfg_bank #(.field_t(can_reg_pkg::bus_timing_t)) timing_bank (
    .clk     (clk),
    .rst     (rst),
    .lane_we (timing_we),
    .data_in (data_in),
    .fields  (bus_timing)
  );

  // Acceptance code and mask
  can_cfg_bank #(.field_t(can_reg_pkg::acc_filter_t)) filter_bank (
    .clk     (clk),
    .rst     (rst),
    .lane_we (filter_we),
    .data_in (data_in),
    .fields  (acc_filter)
  );

  can_status_regs u_status (
    .clk            (clk),
    .rst            (rst),
    .core_status    (core_status),
    .mode           (mode),
    .command        (command),
    .status         (status),
    .tx_buffer_rise (tx_buffer_rise),
    .overrun_rise   (overrun_rise)
  );

  can_irq_unit u_irq (
    .clk            (clk),
    .rst            (rst),
    .core_status    (core_status),
    .mode           (mode),
    .command        (command),
    .irq_en         (irq_en),
    .read_irq       (read_irq),
    .tx_buffer_rise (tx_buffer_rise),
    .overrun_rise   (overrun_rise),
    .irq_flags      (irq_flags),
    .irq_n          (irq_n)
  );

  // ##########################################################################
  // Read multiplexer
  // ##########################################################################

  always_comb begin
    case (addr_read)
      can_reg_pkg::addr_mode:           data_out = {4'b0000, mode};
      can_reg_pkg::addr_status:         data_out = status;
      can_reg_pkg::addr_irq:            data_out = irq_flags;
      can_reg_pkg::addr_irq_en:         data_out = irq_en;
      can_reg_pkg::addr_bus_timing_0:   data_out = bus_timing[7:0];
      can_reg_pkg::addr_bus_timing_1:   data_out = bus_timing[15:8];
      can_reg_pkg::addr_err_warn_limit: data_out = err_warn_limit;
      can_reg_pkg::addr_rx_err_cnt:     data_out = rx_err_cnt;
      can_reg_pkg::addr_tx_err_cnt:     data_out = tx_err_cnt;
      default:                          data_out = '0;
    endcase
    // Filter bytes sit in two contiguous blocks of four
    for (int i = 0; i < 4; i++) begin
      if (addr_read == can_reg_pkg::addr_acc_code_base + 8'(i)) begin
        data_out = acc_filter.acc_code[i];
      end
      if (addr_read == can_reg_pkg::addr_acc_mask_base + 8'(i)) begin
        data_out = acc_filter.acc_mask[i];
      end
    end
  end

endmodule

// ==== verif/can_registers_tb.sv ====
// Checking is done by concurrent assertions, so the simulator must run with assertions enabled
`timescale 1ns/1ns

module can_registers_tb;

  logic                      clk;
  logic                      rst;
  logic                      we;
  logic                      re;
  logic [7:0]                addr_write;
  logic [7:0]                addr_read;
  logic [7:0]                data_in;
  can_reg_pkg::core_status_t core_status;
  logic [7:0]                rx_err_cnt;
  logic [7:0]                tx_err_cnt;
  logic [7:0]                data_out;
  logic                      irq_n;
  can_reg_pkg::mode_t        mode;
  can_reg_pkg::command_t     command;
  can_reg_pkg::bus_timing_t  bus_timing;
  can_reg_pkg::acc_filter_t  acc_filter;
  logic [7:0]                err_warn_limit;

  // Read check request, mask and expected byte
  logic                      chk_rd;
  logic [7:0]                rd_mask;
  logic [7:0]                exp_rd;
  // Interrupt line check request
  logic                      chk_irq;
  logic                      exp_irq;
  // Reference model of the configuration registers
  can_reg_pkg::bus_timing_t  exp_timing;
  can_reg_pkg::acc_filter_t  exp_filter;
  logic [7:0]                exp_limit;
  logic                      exp_reset_mode;
  // Listen only, self test and acceptance filter bits of the mode register
  logic [2:0]                exp_op_mode;

  logic [7:0]                cfg_val [11];
  int                        errors;
  int                        timeouts;
  int                        i;

  can_registers uut (
    .clk            (clk),
    .rst            (rst),
    .we             (we),
    .re             (re),
    .addr_write     (addr_write),
    .addr_read      (addr_read),
    .data_in        (data_in),
    .core_status    (core_status),
    .rx_err_cnt     (rx_err_cnt),
    .tx_err_cnt     (tx_err_cnt),
    .data_out       (data_out),
    .irq_n          (irq_n),
    .mode           (mode),
    .command        (command),
    .bus_timing     (bus_timing),
    .acc_filter     (acc_filter),
    .err_warn_limit (err_warn_limit)
  );

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ##########################################################################
  // Checks
  // ##########################################################################

  // Masked read data, combinational on addr_read
  assert property (@(posedge clk) disable iff (rst) chk_rd |-> (data_out & rd_mask) == exp_rd)
    else begin
      errors = errors + 1;
      $display("error data_out at addr %h: got %h expected %h", $sampled(addr_read),
               $sampled(data_out) & $sampled(rd_mask), $sampled(exp_rd));
    end

  assert property (@(posedge clk) disable iff (rst) chk_irq |-> irq_n == exp_irq)
    else begin
      errors = errors + 1;
      $display("error irq_n: got %h expected %h", $sampled(irq_n), $sampled(exp_irq));
    end

  // Outputs follow the model, which moves at the capturing edge
  assert property (@(posedge clk) disable iff (rst) bus_timing == exp_timing)
    else begin
      errors = errors + 1;
      $display("error bus_timing: got %h expected %h", $sampled(bus_timing),
               $sampled(exp_timing));
    end

  assert property (@(posedge clk) disable iff (rst) acc_filter == exp_filter)
    else begin
      errors = errors + 1;
      $display("error acc_filter: got %h expected %h", $sampled(acc_filter),
               $sampled(exp_filter));
    end

  assert property (@(posedge clk) disable iff (rst) err_warn_limit == exp_limit)
    else begin
      errors = errors + 1;
      $display("error err_warn_limit: got %h expected %h", $sampled(err_warn_limit),
               $sampled(exp_limit));
    end

  assert property (@(posedge clk) disable iff (rst) mode == {exp_op_mode, exp_reset_mode})
    else begin
      errors = errors + 1;
      $display("error mode: got %h expected %h", $sampled(mode),
               {$sampled(exp_op_mode), $sampled(exp_reset_mode)});
    end

  // Request bit set on the cycle after the command write
  assert property (@(posedge clk) disable iff (rst)
    (we && addr_write == can_reg_pkg::addr_command && data_in[0] && !exp_reset_mode &&
     !core_status.sample_point) |=> command.tx_request)
    else begin
      errors = errors + 1;
      $display("error command.tx_request: got %h expected 1", $sampled(command.tx_request));
    end

  // First sample point ends the request
  assert property (@(posedge clk) disable iff (rst)
    (command.tx_request && core_status.sample_point) |=> !command.tx_request)
    else begin
      errors = errors + 1;
      $display("error command.tx_request: got %h expected 0", $sampled(command.tx_request));
    end

  assert property (@(posedge clk) disable iff (rst)
    (re && addr_read == can_reg_pkg::addr_irq) |=> irq_n)
    else begin
      errors = errors + 1;
      $display("error irq_n after interrupt read: got %h expected 1", $sampled(irq_n));
    end

  assert property (@(posedge clk) disable iff (rst) command.release_buffer |=> irq_n)
    else begin
      errors = errors + 1;
      $display("error irq_n after buffer release: got %h expected 1", $sampled(irq_n));
    end

  // ##########################################################################
  // Host bus tasks
  // ##########################################################################

  // Index 0..10 maps to timing 0, timing 1, error limit, code 0..3, mask 0..3
  function automatic logic [7:0] cfg_addr(input int idx);
    case (idx)
      0:       cfg_addr = can_reg_pkg::addr_bus_timing_0;
      1:       cfg_addr = can_reg_pkg::addr_bus_timing_1;
      2:       cfg_addr = can_reg_pkg::addr_err_warn_limit;
      default: cfg_addr = (idx < 7) ? can_reg_pkg::addr_acc_code_base + 8'(idx - 3)
                                    : can_reg_pkg::addr_acc_mask_base + 8'(idx - 7);
    endcase
  endfunction

  task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
    can_reg_pkg::bus_timing_t next_timing;
    can_reg_pkg::acc_filter_t next_filter;
    logic [7:0]               next_limit;
    int                       k;
    @(posedge clk);
    we         <= 1'b1;
    addr_write <= addr;
    data_in    <= data;
    @(posedge clk);
    we          <= 1'b0;
    next_timing = exp_timing;
    next_filter = exp_filter;
    next_limit  = exp_limit;
    // Configuration only changes in reset mode
    if (exp_reset_mode) begin
      if (addr == can_reg_pkg::addr_bus_timing_0) begin
        next_timing[7:0] = data;
      end
      if (addr == can_reg_pkg::addr_bus_timing_1) begin
        next_timing[15:8] = data;
      end
      if (addr == can_reg_pkg::addr_err_warn_limit) begin
        next_limit = data;
      end
      for (k = 0; k < 4; k++) begin
        if (addr == can_reg_pkg::addr_acc_code_base + 8'(k)) begin
          next_filter.acc_code[k] = data;
        end
        if (addr == can_reg_pkg::addr_acc_mask_base + 8'(k)) begin
          next_filter.acc_mask[k] = data;
        end
      end
    end
    exp_timing <= next_timing;
    exp_filter <= next_filter;
    exp_limit  <= next_limit;
    if (addr == can_reg_pkg::addr_mode) begin
      exp_reset_mode <= data[0];
      exp_op_mode    <= data[3:1];
    end
  endtask

  // One cycle on addr_read, with re raised only for a clearing read
  task automatic check_read(input logic [7:0] addr, input logic [7:0] mask,
                            input logic [7:0] expected, input logic clear);
    @(posedge clk);
    addr_read <= addr;
    rd_mask   <= mask;
    exp_rd    <= expected;
    re        <= clear;
    chk_rd    <= 1'b1;
    @(posedge clk);
    re     <= 1'b0;
    chk_rd <= 1'b0;
  endtask

  task automatic check_irq(input logic expected);
    @(posedge clk);
    exp_irq <= expected;
    chk_irq <= 1'b1;
    @(posedge clk);
    chk_irq <= 1'b0;
  endtask

  // Sampled at the falling edge, away from register updates
  task automatic wait_irq_low(input int max_cycles, input string cause);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < max_cycles) begin
      @(negedge clk);
      n    = n + 1;
      seen = !irq_n;
    end
    if (!seen) begin
      timeouts = timeouts + 1;
      $display("timeout: irq_n did not fall within %0d cycles of the %s event", max_cycles,
               cause);
    end
  endtask

  // ##########################################################################
  // Stimulus
  // ##########################################################################

  initial begin
    void'($urandom(32'hc960));
    rst            = 1'b1;
    we             = 1'b0;
    re             = 1'b0;
    addr_write     = '0;
    addr_read      = '0;
    data_in        = '0;
    core_status    = '0;
    rx_err_cnt     = '0;
    tx_err_cnt     = '0;
    chk_rd         = 1'b0;
    rd_mask        = '0;
    exp_rd         = '0;
    chk_irq        = 1'b0;
    exp_irq        = 1'b1;
    exp_timing     = '0;
    exp_filter     = '0;
    exp_limit      = can_reg_pkg::err_warn_limit_reset;
    exp_reset_mode = 1'b1;
    exp_op_mode    = '0;
    errors         = 0;
    timeouts       = 0;
    for (i = 0; i < 11; i++) begin
      cfg_val[i] = 8'($urandom);
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // After reset, core inputs all low
    check_irq(1'b1);
    check_read(can_reg_pkg::addr_mode, 8'hff, 8'h01, 1'b0);
    check_read(can_reg_pkg::addr_status, 8'hff, 8'h0c, 1'b0);
    check_read(can_reg_pkg::addr_err_warn_limit, 8'hff, 8'h60, 1'b0);
    // Empty receive FIFO from here on
    @(posedge clk);
    core_status.info_empty <= 1'b1;
    rx_err_cnt             <= cfg_val[0];
    tx_err_cnt             <= cfg_val[1];
    check_read(can_reg_pkg::addr_rx_err_cnt, 8'hff, cfg_val[0], 1'b0);
    check_read(can_reg_pkg::addr_tx_err_cnt, 8'hff, cfg_val[1], 1'b0);

    // Configuration in reset mode, then locked outside it
    for (i = 0; i < 11; i++) begin
      write_reg(cfg_addr(i), cfg_val[i]);
    end
    for (i = 0; i < 11; i++) begin
      check_read(cfg_addr(i), 8'hff, cfg_val[i], 1'b0);
    end
    write_reg(can_reg_pkg::addr_mode, 8'h00);
    check_read(can_reg_pkg::addr_mode, 8'hff, 8'h00, 1'b0);
    for (i = 0; i < 11; i++) begin
      write_reg(cfg_addr(i), ~cfg_val[i]);
    end
    for (i = 0; i < 11; i++) begin
      check_read(cfg_addr(i), 8'hff, cfg_val[i], 1'b0);
    end

    // Transmit request held until a sample point
    write_reg(can_reg_pkg::addr_command, 8'h01);
    check_read(can_reg_pkg::addr_status, 8'h04, 8'h00, 1'b0);
    @(posedge clk);
    core_status.sample_point <= 1'b1;
    @(posedge clk);
    core_status.sample_point <= 1'b0;

    // Receive interrupt, released by the buffer release command
    write_reg(can_reg_pkg::addr_irq_en, 8'h01);
    @(posedge clk);
    core_status.info_empty <= 1'b0;
    wait_irq_low(4, "receive");
    check_read(can_reg_pkg::addr_irq, 8'h01, 8'h01, 1'b0);
    @(posedge clk);
    core_status.info_empty <= 1'b1;
    write_reg(can_reg_pkg::addr_command, 8'h04);
    check_read(can_reg_pkg::addr_irq, 8'h01, 8'h00, 1'b0);
    check_irq(1'b1);

    // Overrun status and interrupt
    write_reg(can_reg_pkg::addr_irq_en, 8'h08);
    @(posedge clk);
    core_status.overrun <= 1'b1;
    wait_irq_low(4, "overrun");
    check_read(can_reg_pkg::addr_status, 8'h02, 8'h02, 1'b0);
    check_read(can_reg_pkg::addr_irq, 8'h08, 8'h08, 1'b0);
    // Clearing read still returns the flag
    check_read(can_reg_pkg::addr_irq, 8'h08, 8'h08, 1'b1);
    check_read(can_reg_pkg::addr_irq, 8'h08, 8'h00, 1'b0);
    check_irq(1'b1);
    write_reg(can_reg_pkg::addr_command, 8'h08);
    check_read(can_reg_pkg::addr_status, 8'h02, 8'h00, 1'b0);
    @(posedge clk);
    core_status.overrun <= 1'b0;
    repeat (2) @(posedge clk);

    $display("errors: %0d failed checks, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== all.f ====
source/can_reg_pkg.sv
source/can_cfg_bank.sv
source/can_reg_ctrl.sv
source/can_status_regs.sv
source/can_irq_unit.sv
source/can_registers.sv
verif/can_registers_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the register file testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module can_registers_tb \
  -o sim_can_registers > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_can_registers > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation ended with an error status"
  exit 1
fi
exit 0
